// ==== axi3_write_conv.f ====
+incdir+logic
logic/conv_pkg.sv
logic/aw_split.sv
logic/cmd_fifo.sv
logic/w_axi3_conv.sv
logic/b_merge.sv
logic/axi3_write_conv.sv
bench/clock_gen.sv
bench/tb_axi3_write_conv.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_axi3_write_conv
FILELIST  := axi3_write_conv.f
OBJDIR    := obj_dir
LOG       := sim.log
SRCS      := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
	  echo "Simulation failed."; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/tb_axi3_write_conv.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module tb_axi3_write_conv;

  localparam int DATA_W          = `CONV_DATA_WIDTH;
  localparam int STRB_W          = `CONV_STRB_WIDTH;
  localparam int ADDR_W          = `CONV_ADDR_WIDTH;
  localparam int FIXED_BEATS     = 692; // Beats in the directed tests.
  localparam int RAND_BURSTS     = 24;
  localparam int RAND_MAX_LEN    = 63;
  localparam int TOTAL_BEATS     = FIXED_BEATS + RAND_BURSTS * (RAND_MAX_LEN + 1);
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 4000;

  logic               ACLK;
  logic               ARESET;
  conv_pkg::aw4_t     s_aw;
  logic               s_awvalid;
  logic               s_awready;
  conv_pkg::w_beat_t  s_w;
  logic               s_wvalid;
  logic               s_wready;
  conv_pkg::b_t       s_b;
  logic               s_bvalid;
  logic               s_bready;
  conv_pkg::aw3_t     m_aw;
  logic               m_awvalid;
  logic               m_awready;
  conv_pkg::w3_beat_t m_w;
  logic               m_wvalid;
  logic               m_wready;
  conv_pkg::b_t       m_b;
  logic               m_bvalid;
  logic               m_bready;

  conv_pkg::aw3_t     exp_aw_q[$];
  conv_pkg::w3_beat_t exp_w_q[$];
  conv_pkg::b_t       exp_b_q[$];
  conv_pkg::w_beat_t  drive_w_q[$];
  conv_pkg::aw3_t     slave_aw_q[$];
  conv_pkg::b_t       slave_b_q[$];
  conv_pkg::aw3_t     exp_aw_head;
  conv_pkg::w3_beat_t exp_w_head;
  conv_pkg::b_t       exp_b_head;
  int                 aw_pending = 0;
  int                 w_pending = 0;
  int                 b_pending = 0;
  int                 error_count = 0;
  int                 test_err_start = 0;
  int                 tests_run = 0;
  int                 tests_passed = 0;
  logic               rst_seen = 1'b0;
  logic               rst_d = 1'b0;

  clock_gen u_clock_gen (
    .ACLK   (ACLK),
    .ARESET (ARESET)
  );

  axi3_write_conv UUT (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .s_aw      (s_aw),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_w       (s_w),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_b       (s_b),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .m_aw      (m_aw),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),
    .m_b       (m_b),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready)
  );

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    error_count++;
  endtask

  task automatic flow_error(input string what);
    $display("Failure at %0t: %s", $time, what);
    error_count++;
  endtask

  function automatic conv_pkg::aw4_t make_aw(input int id, input logic [31:0] addr,
                                             input int len, input int size,
                                             input conv_pkg::burst_e burst);
    conv_pkg::aw4_t aw;
    aw.id    = `CONV_ID_WIDTH'(id);
    aw.addr  = ADDR_W'(addr);
    aw.len   = 8'(len);
    aw.size  = 3'(size);
    aw.burst = burst;
    return aw;
  endfunction

  // Expected sub-bursts come straight from the splitting rule.
  task automatic queue_burst(input conv_pkg::aw4_t aw);
    int                 remain;
    int                 k;
    int                 n;
    conv_pkg::aw3_t     sub;
    conv_pkg::w_beat_t  beat;
    conv_pkg::w3_beat_t mbeat;
    conv_pkg::b_t       rsp;
    remain   = int'(aw.len) + 1;
    k        = 0;
    rsp.id   = aw.id;
    rsp.resp = conv_pkg::RESP_OKAY;
    while (remain > 0) begin
      n         = (remain > 16) ? 16 : remain;
      sub.id    = aw.id;
      sub.addr  = aw.addr;
      sub.len   = 4'(n - 1);
      sub.size  = aw.size;
      sub.burst = aw.burst;
      if (aw.burst == conv_pkg::BURST_INCR) begin
        sub.addr = aw.addr + (ADDR_W'(k * 16) << aw.size);
      end
      exp_aw_q.push_back(sub);
      if (sub.addr[12]) begin
        rsp.resp = conv_pkg::RESP_SLVERR; // The slave model rejects this region.
      end
      for (int i = 0; i < n; i++) begin
        beat.data  = DATA_W'($urandom());
        beat.strb  = STRB_W'($urandom());
        beat.last  = (remain - i == 1);
        mbeat.id   = aw.id;
        mbeat.data = beat.data;
        mbeat.strb = beat.strb;
        mbeat.last = (i == n - 1);
        drive_w_q.push_back(beat);
        exp_w_q.push_back(mbeat);
      end
      remain -= n;
      k++;
    end
    exp_b_q.push_back(rsp);
  endtask

  task automatic run_burst(input conv_pkg::aw4_t aw);
    int beats;
    beats = int'(aw.len) + 1;
    queue_burst(aw);
    s_aw      = aw;
    s_awvalid = 1'b1;
    @(posedge ACLK);
    while (!s_awready) @(posedge ACLK);
    #1;
    s_awvalid = 1'b0;
    repeat (beats) begin
      if ($urandom_range(3) == 0) begin
        @(posedge ACLK); // Idle cycle on the AXI4 write data.
        #1;
      end
      s_w      = drive_w_q.pop_front();
      s_wvalid = 1'b1;
      @(posedge ACLK);
      while (!s_wready) @(posedge ACLK);
      #1;
      s_wvalid = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    while (exp_aw_q.size() != 0 || exp_w_q.size() != 0 || exp_b_q.size() != 0) begin
      @(posedge ACLK);
    end
    repeat (2) @(posedge ACLK);
    #1;
    tests_run++;
    if (error_count == test_err_start) begin
      tests_passed++;
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               error_count - test_err_start);
    end
    test_err_start = error_count;
  endtask

  // AXI3 slave with random stalls. It also stalls the upstream B ready.
  always @(posedge ACLK) begin
    bit             b_taken;
    conv_pkg::aw3_t sub;
    conv_pkg::b_t   rsp;
    b_taken = m_bvalid && m_bready;
    if (m_awvalid && m_awready) begin
      slave_aw_q.push_back(m_aw);
    end
    if (m_wvalid && m_wready && m_w.last && slave_aw_q.size() != 0) begin
      sub      = slave_aw_q.pop_front();
      rsp.id   = sub.id;
      rsp.resp = sub.addr[12] ? conv_pkg::RESP_SLVERR : conv_pkg::RESP_OKAY;
      slave_b_q.push_back(rsp);
    end
    #1;
    if (b_taken) begin
      m_bvalid = 1'b0;
    end
    if (!m_bvalid && slave_b_q.size() != 0 && $urandom_range(3) != 0) begin
      m_b      = slave_b_q.pop_front();
      m_bvalid = 1'b1;
    end
    m_awready = ($urandom_range(3) != 0);
    m_wready  = ($urandom_range(3) != 0);
    s_bready  = ($urandom_range(3) != 0);
  end

  always @(posedge ACLK) begin
    if (!ARESET) begin
      if (m_awvalid && m_awready && exp_aw_q.size() != 0) begin
        void'(exp_aw_q.pop_front());
      end
      if (m_wvalid && m_wready && exp_w_q.size() != 0) begin
        void'(exp_w_q.pop_front());
      end
      if (s_bvalid && s_bready && exp_b_q.size() != 0) begin
        void'(exp_b_q.pop_front());
      end
    end
  end

  // Heads move away from the rising edge so every check sees a settled value.
  always @(negedge ACLK) begin
    aw_pending  = exp_aw_q.size();
    w_pending   = exp_w_q.size();
    b_pending   = exp_b_q.size();
    exp_aw_head = (aw_pending != 0) ? exp_aw_q[0] : '0;
    exp_w_head  = (w_pending != 0) ? exp_w_q[0] : '0;
    exp_b_head  = (b_pending != 0) ? exp_b_q[0] : '0;
  end

  always @(posedge ACLK) begin
    rst_d <= ARESET;
    if (ARESET) begin
      rst_seen <= 1'b1;
    end
  end

  a_aw_expected: assert property (@(posedge ACLK) disable iff (ARESET)
    m_awvalid && m_awready |-> aw_pending != 0)
    else flow_error("AXI3 address transferred when none was expected");
  a_aw_value: assert property (@(posedge ACLK) disable iff (ARESET)
    m_awvalid && m_awready && aw_pending != 0 |-> m_aw == exp_aw_head)
    else value_error("m_aw", $sampled(m_aw), $sampled(exp_aw_head));
  a_w_expected: assert property (@(posedge ACLK) disable iff (ARESET)
    m_wvalid && m_wready |-> w_pending != 0)
    else flow_error("AXI3 data beat transferred when none was expected");
  a_w_value: assert property (@(posedge ACLK) disable iff (ARESET)
    m_wvalid && m_wready && w_pending != 0 |-> m_w == exp_w_head)
    else value_error("m_w", $sampled(m_w), $sampled(exp_w_head));
  a_b_expected: assert property (@(posedge ACLK) disable iff (ARESET)
    s_bvalid && s_bready |-> b_pending != 0)
    else flow_error("AXI4 response returned when none was expected");
  a_b_value: assert property (@(posedge ACLK) disable iff (ARESET)
    s_bvalid && s_bready && b_pending != 0 |-> s_b == exp_b_head)
    else value_error("s_b", $sampled(s_b), $sampled(exp_b_head));
  a_reset_quiet: assert property (@(posedge ACLK)
    rst_seen && (ARESET || rst_d) |-> !m_awvalid && !m_wvalid && !s_bvalid)
    else flow_error("valid raised during reset or on the cycle after it");

  initial begin
    conv_pkg::aw4_t aw;
    void'($urandom(32'h8551abf6));
    s_aw      = '0;
    s_awvalid = 1'b1; // Requests offered during reset must be ignored.
    s_w       = '0;
    s_wvalid  = 1'b1;
    s_bready  = 1'b0;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_b       = '0;
    m_bvalid  = 1'b0;
    @(negedge ARESET);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    @(posedge ACLK);
    #1;
    run_burst(make_aw(1, 32'h0000_0100, 15, 2, conv_pkg::BURST_INCR));
    run_burst(make_aw(2, 32'h0000_2000, 3, 1, conv_pkg::BURST_INCR));
    run_burst(make_aw(3, 32'h0000_0340, 7, 2, conv_pkg::BURST_WRAP));
    end_test("short bursts pass through");
    run_burst(make_aw(4, 32'h0002_0000, 255, 2, conv_pkg::BURST_INCR));
    end_test("256-beat INCR split");
    run_burst(make_aw(5, 32'h0000_0400, 39, 2, conv_pkg::BURST_INCR));
    run_burst(make_aw(6, 32'h0000_0800, 39, 2, conv_pkg::BURST_FIXED));
    end_test("40-beat INCR and FIXED split");
    run_burst(make_aw(7, 32'h0000_0F00, 255, 2, conv_pkg::BURST_INCR));
    run_burst(make_aw(8, 32'h0000_1004, 39, 2, conv_pkg::BURST_FIXED));
    run_burst(make_aw(9, 32'h0000_0E00, 31, 2, conv_pkg::BURST_INCR));
    end_test("merged responses");
    repeat (RAND_BURSTS) begin
      aw = make_aw($urandom_range(15), $urandom() & 32'hFFFF_FFF0,
                   $urandom_range(RAND_MAX_LEN), $urandom_range(2),
                   ($urandom_range(1) != 0) ? conv_pkg::BURST_INCR : conv_pkg::BURST_FIXED);
      run_burst(aw);
    end
    end_test("random bursts under stalls");
    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
             tests_run - tests_passed, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ACLK);
    $display("Watchdog expired after %0d cycles, %0d responses still outstanding",
             WATCHDOG_CYCLES, exp_b_q.size());
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic ACLK,
  output logic ARESET
);

  initial begin
    ACLK = 1'b0;
    forever #(PERIOD_NS / 2) ACLK = ~ACLK;
  end

  // Reset drops 1 ns after the last reset edge.
  initial begin
    ARESET = 1'b1;
    repeat (RESET_CYCLES) @(posedge ACLK);
    #1;
    ARESET = 1'b0;
  end

endmodule

// ==== logic/axi3_write_conv.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module axi3_write_conv (
  input  logic                ACLK,
  input  logic                ARESET,
  input  conv_pkg::aw4_t      s_aw,
  input  logic                s_awvalid,
  output logic                s_awready,
  input  conv_pkg::w_beat_t   s_w,
  input  logic                s_wvalid,
  output logic                s_wready,
  output conv_pkg::b_t        s_b,
  output logic                s_bvalid,
  input  logic                s_bready,
  output conv_pkg::aw3_t      m_aw,
  output logic                m_awvalid,
  input  logic                m_awready,
  output conv_pkg::w3_beat_t  m_w,
  output logic                m_wvalid,
  input  logic                m_wready,
  input  conv_pkg::b_t        m_b,
  input  logic                m_bvalid,
  output logic                m_bready
);

  localparam int W_CMD_WIDTH = $bits(conv_pkg::w_cmd_t);
  localparam int B_CMD_WIDTH = $bits(conv_pkg::b_cmd_t);

  conv_pkg::w_cmd_t w_push;
  logic             w_push_valid;
  logic             w_push_ready;
  conv_pkg::w_cmd_t w_pop;
  logic             w_pop_valid;
  logic             w_pop_ready;

  conv_pkg::b_cmd_t b_push;
  logic             b_push_valid;
  logic             b_push_ready;
  conv_pkg::b_cmd_t b_pop;
  logic             b_pop_valid;
  logic             b_pop_ready;

  aw_split u_aw_split (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .s_aw        (s_aw),
    .s_awvalid   (s_awvalid),
    .s_awready   (s_awready),
    .m_aw        (m_aw),
    .m_awvalid   (m_awvalid),
    .m_awready   (m_awready),
    .w_cmd       (w_push),
    .w_cmd_valid (w_push_valid),
    .w_cmd_ready (w_push_ready),
    .b_cmd       (b_push),
    .b_cmd_valid (b_push_valid),
    .b_cmd_ready (b_push_ready)
  );

  cmd_fifo #(
    .WIDTH (W_CMD_WIDTH),
    .DEPTH (`CONV_QUEUE_DEPTH)
  ) u_w_queue (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .in_data   (w_push),
    .in_valid  (w_push_valid),
    .in_ready  (w_push_ready),
    .out_data  (w_pop),
    .out_valid (w_pop_valid),
    .out_ready (w_pop_ready)
  );

  cmd_fifo #(
    .WIDTH (B_CMD_WIDTH),
    .DEPTH (`CONV_QUEUE_DEPTH)
  ) u_b_queue (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .in_data   (b_push),
    .in_valid  (b_push_valid),
    .in_ready  (b_push_ready),
    .out_data  (b_pop),
    .out_valid (b_pop_valid),
    .out_ready (b_pop_ready)
  );

  w_axi3_conv u_w_conv (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .cmd       (w_pop),
    .cmd_valid (w_pop_valid),
    .cmd_ready (w_pop_ready),
    .s_w       (s_w),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .m_w       (m_w),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready)
  );

  b_merge u_b_merge (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .b_cmd       (b_pop),
    .b_cmd_valid (b_pop_valid),
    .b_cmd_ready (b_pop_ready),
    .m_b         (m_b),
    .m_bvalid    (m_bvalid),
    .m_bready    (m_bready),
    .s_b         (s_b),
    .s_bvalid    (s_bvalid),
    .s_bready    (s_bready)
  );

endmodule

// ==== logic/b_merge.sv ====
`timescale 1ns/1ps

module b_merge (
  input  logic              ACLK,
  input  logic              ARESET,
  input  conv_pkg::b_cmd_t  b_cmd,
  input  logic              b_cmd_valid,
  output logic              b_cmd_ready,
  input  conv_pkg::b_t      m_b,
  input  logic              m_bvalid,
  output logic              m_bready,
  output conv_pkg::b_t      s_b,
  output logic              s_bvalid,
  input  logic              s_bready
);

  conv_pkg::resp_e worst_q;
  conv_pkg::resp_e merged;
  logic            is_last;
  logic            pop;

  always_comb begin
    if (worst_q == conv_pkg::RESP_DECERR || m_b.resp == conv_pkg::RESP_DECERR) begin
      merged = conv_pkg::RESP_DECERR;
    end else if (worst_q == conv_pkg::RESP_SLVERR || m_b.resp == conv_pkg::RESP_SLVERR) begin
      merged = conv_pkg::RESP_SLVERR;
    end else begin
      merged = m_b.resp;
    end
  end

  assign is_last = b_cmd.last_of_split;

  // Intermediate responses are absorbed and only the final one goes upstream.
  assign m_bready    = b_cmd_valid & (is_last ? s_bready : 1'b1);
  assign s_bvalid    = m_bvalid & b_cmd_valid & is_last;
  assign pop         = m_bvalid & m_bready;
  assign b_cmd_ready = pop;

  assign s_b.id   = m_b.id;
  assign s_b.resp = merged;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      worst_q <= conv_pkg::RESP_OKAY;
    end else if (pop) begin
      worst_q <= is_last ? conv_pkg::RESP_OKAY : merged;
    end
  end

  // AXI3 responses come back in the order the addresses were issued.
  a_id_match: assert property (@(posedge ACLK) disable iff (ARESET)
    m_bvalid && b_cmd_valid |-> m_b.id == b_cmd.id);

endmodule

// ==== logic/w_axi3_conv.sv ====
`timescale 1ns/1ps

module w_axi3_conv (
  input  logic                ACLK,
  input  logic                ARESET,
  input  conv_pkg::w_cmd_t    cmd,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  conv_pkg::w_beat_t   s_w,
  input  logic                s_wvalid,
  output logic                s_wready,
  output conv_pkg::w3_beat_t  m_w,
  output logic                m_wvalid,
  input  logic                m_wready
);

  logic       first_word;
  logic [3:0] count_q;
  logic [3:0] count_cur;
  logic       last_word;
  logic       pop_beat;
  logic       stalling;

  assign m_wvalid = s_wvalid & cmd_valid;
  assign stalling = m_wvalid & ~m_wready;
  assign s_wready = s_wvalid & cmd_valid & ~stalling;
  assign pop_beat = m_wvalid & m_wready;

  // The first beat of a sub-burst takes its length from the command.
  assign count_cur = first_word ? cmd.len : count_q;
  assign last_word = (count_cur == 4'd0);
  assign cmd_ready = cmd_valid & pop_beat & last_word;

  assign m_w.id   = cmd.id;
  assign m_w.data = s_w.data;
  assign m_w.strb = s_w.strb;
  assign m_w.last = last_word; // AXI4 WLAST is not used here.

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_word <= 1'b1;
      count_q    <= 4'd0;
    end else if (pop_beat) begin
      first_word <= last_word;
      count_q    <= count_cur - 4'd1;
    end
  end

  // A stalled beat keeps its command in the W queue.
  a_cmd_held: assert property (@(posedge ACLK) disable iff (ARESET)
    m_wvalid && !m_wready |=> cmd_valid);

endmodule

// ==== logic/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             ACLK,
  input  logic             ARESET,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // The head entry is never overwritten while the consumer stalls.
  a_head_held: assert property (@(posedge ACLK) disable iff (ARESET)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  // Read and write pointers meet only when the queue is empty or full.
  a_ptr_meet: assert property (@(posedge ACLK) disable iff (ARESET)
    (wr_ptr == rd_ptr) == (count == '0 || count == CNT_W'(DEPTH)));

endmodule

// ==== logic/aw_split.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module aw_split (
  input  logic            ACLK,
  input  logic            ARESET,
  input  conv_pkg::aw4_t  s_aw,
  input  logic            s_awvalid,
  output logic            s_awready,
  output conv_pkg::aw3_t  m_aw,
  output logic            m_awvalid,
  input  logic            m_awready,
  output conv_pkg::w_cmd_t w_cmd,
  output logic            w_cmd_valid,
  input  logic            w_cmd_ready,
  output conv_pkg::b_cmd_t b_cmd,
  output logic            b_cmd_valid,
  input  logic            b_cmd_ready
);

  conv_pkg::split_state_e      state_q;
  logic [`CONV_ID_WIDTH-1:0]   id_q;
  logic [`CONV_ADDR_WIDTH-1:0] addr_q;
  logic [2:0]                  size_q;
  conv_pkg::burst_e            burst_q;
  logic [8:0]                  remain_q; // Beats still to be issued, 1 to 256.
  logic                        issuing;
  logic                        last_sub;
  logic [3:0]                  sub_len;
  logic                        fire;
  logic [`CONV_ADDR_WIDTH-1:0] addr_step;

  assign issuing  = (state_q == conv_pkg::SPLIT_ISSUE);
  assign last_sub = (remain_q <= 9'(`CONV_AXI3_MAX_BEATS));
  assign sub_len  = last_sub ? 4'(remain_q - 9'd1) : 4'd15;

  // The queues only fill through this block, so once both report room they
  // keep it until the next issue and m_awvalid stays up once raised.
  assign m_awvalid   = issuing & w_cmd_ready & b_cmd_ready;
  assign w_cmd_valid = issuing & m_awready & b_cmd_ready;
  assign b_cmd_valid = issuing & m_awready & w_cmd_ready;
  assign fire        = issuing & m_awready & w_cmd_ready & b_cmd_ready;

  assign s_awready = (state_q == conv_pkg::SPLIT_IDLE);

  assign addr_step = (burst_q == conv_pkg::BURST_INCR) ?
                     (`CONV_ADDR_WIDTH'(`CONV_AXI3_MAX_BEATS) << size_q) :
                     '0;

  assign m_aw.id    = id_q;
  assign m_aw.addr  = addr_q;
  assign m_aw.len   = sub_len;
  assign m_aw.size  = size_q;
  assign m_aw.burst = burst_q;

  assign w_cmd.id  = id_q;
  assign w_cmd.len = sub_len;

  assign b_cmd.id            = id_q;
  assign b_cmd.last_of_split = last_sub;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state_q <= conv_pkg::SPLIT_IDLE;
    end else begin
      case (state_q)
        conv_pkg::SPLIT_IDLE: begin
          if (s_awvalid) begin
            state_q <= conv_pkg::SPLIT_ISSUE;
          end
        end
        conv_pkg::SPLIT_ISSUE: begin
          if (fire && last_sub) begin
            state_q <= conv_pkg::SPLIT_IDLE;
          end
        end
        default: state_q <= conv_pkg::SPLIT_IDLE;
      endcase
    end
  end

  // Fields of the accepted burst and the running address.
  always_ff @(posedge ACLK) begin
    if (s_awready && s_awvalid) begin
      id_q     <= s_aw.id;
      addr_q   <= s_aw.addr;
      size_q   <= s_aw.size;
      burst_q  <= s_aw.burst;
      remain_q <= 9'(s_aw.len) + 9'd1;
    end else if (fire) begin
      addr_q   <= addr_q + addr_step;
      remain_q <= remain_q - 9'(`CONV_AXI3_MAX_BEATS);
    end
  end

  // A sub-burst never asks for more beats than the AXI4 burst has left.
  a_len_in_range: assert property (@(posedge ACLK) disable iff (ARESET)
    m_awvalid |-> (m_aw.len <= 4'd15) && (9'(m_aw.len) < remain_q));

  // The address stays put while the AXI3 slave stalls.
  a_aw_stable: assert property (@(posedge ACLK) disable iff (ARESET)
    m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw));

endmodule

// ==== logic/conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_ISSUE
  } split_state_e;

  typedef struct packed {
    logic [`CONV_ID_WIDTH-1:0]   id;
    logic [`CONV_ADDR_WIDTH-1:0] addr;
    logic [7:0]                  len;
    logic [2:0]                  size;
    burst_e                      burst;
  } aw4_t;

  typedef struct packed {
    logic [`CONV_ID_WIDTH-1:0]   id;
    logic [`CONV_ADDR_WIDTH-1:0] addr;
    logic [3:0]                  len; // AXI3 allows 16 beats at most.
    logic [2:0]                  size;
    burst_e                      burst;
  } aw3_t;

  typedef struct packed {
    logic [`CONV_DATA_WIDTH-1:0] data;
    logic [`CONV_STRB_WIDTH-1:0] strb;
    logic                        last;
  } w_beat_t;

  typedef struct packed {
    logic [`CONV_ID_WIDTH-1:0]   id;
    logic [`CONV_DATA_WIDTH-1:0] data;
    logic [`CONV_STRB_WIDTH-1:0] strb;
    logic                        last;
  } w3_beat_t;

  typedef struct packed {
    logic [`CONV_ID_WIDTH-1:0] id;
    logic [3:0]                len; // Beats in the sub-burst minus one.
  } w_cmd_t;

  typedef struct packed {
    logic [`CONV_ID_WIDTH-1:0] id;
    logic                      last_of_split;
  } b_cmd_t;

  typedef struct packed {
    logic [`CONV_ID_WIDTH-1:0] id;
    resp_e                     resp;
  } b_t;

endpackage

// ==== logic/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Transaction ID width, shared by AW, W and B.
`define CONV_ID_WIDTH 4

// Byte address width on both sides.
`define CONV_ADDR_WIDTH 32

// Write data width. The strobe carries one bit per byte.
`define CONV_DATA_WIDTH 32
`define CONV_STRB_WIDTH (`CONV_DATA_WIDTH / 8)

// Entries in the W and B command queues.
`define CONV_QUEUE_DEPTH 4

// An AXI3 burst holds at most this many beats.
`define CONV_AXI3_MAX_BEATS 16

`endif
